/* common/pixel_pkg.sv */
// Pixel and coefficient types
`default_nettype none

package pixel_pkg;

    // ------------------------------------------------------------------
    // Block geometry
    // ------------------------------------------------------------------

    // One 4x4 block, row-major
    localparam int BLK_PIXELS = 16;

    // ------------------------------------------------------------------
    // Sample and transform widths
    // ------------------------------------------------------------------

    // Raw 8-bit sample
    typedef logic [7:0] pixel_t;

    // Original minus prediction
    typedef logic signed [8:0] resid_t;

    // Second butterfly stage output
    typedef logic signed [12:0] coef_t;

    // Magnitude of a coefficient, at most 16 * 255
    typedef logic [11:0] abs_coef_t;

    // Per-coefficient weight
    typedef logic [7:0] weight_t;

endpackage : pixel_pkg

`default_nettype wire

/* common/cost_pkg.sv */
// Cost and selection types
`default_nettype none

package cost_pkg;

    // ------------------------------------------------------------------
    // Scores and costs
    // ------------------------------------------------------------------

    // Weighted SATD and SAD share one width
    typedef logic [23:0] score_t;

    // SATD plus the lambda-scaled SAD
    typedef logic [25:0] cost_t;

    // Fixed point, 4 fraction bits
    typedef logic [7:0] lambda_t;

    // Candidate position within its group
    typedef logic [7:0] cand_idx_t;

    // ------------------------------------------------------------------
    // Default configuration
    // ------------------------------------------------------------------

    localparam int DEF_QUEUE_DEPTH  = 4;
    localparam int DEF_WEIGHT_SHIFT = 4;
    localparam int DEF_OUT_CREDITS  = 2;

endpackage : cost_pkg

`default_nettype wire

/* hadamard/hadamard_cost.sv */
// Weighted 4x4 SATD
`default_nettype none
`timescale 1ns/100ps

module hadamard_cost #(
    parameter int WEIGHT_SHIFT = cost_pkg::DEF_WEIGHT_SHIFT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cand_valid_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0]  org_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0]  pred_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::weight_t)-1:0] weights_i,
    input  logic                group_last_i,
    output cost_pkg::score_t    satd_o,
    output logic                satd_valid_o,
    output logic                group_last_o
);

    import pixel_pkg::*;
    import cost_pkg::*;

    localparam int PW = $bits(pixel_t);
    localparam int WW = $bits(weight_t);

    pixel_t             org_px  [BLK_PIXELS];
    pixel_t             pred_px [BLK_PIXELS];
    weight_t            w_px    [BLK_PIXELS];
    resid_t             resid   [BLK_PIXELS];
    logic signed [10:0] row_c   [BLK_PIXELS];
    coef_t              coef    [BLK_PIXELS];

    abs_coef_t          abs_q   [BLK_PIXELS];
    logic               s1_valid_q;
    logic               s1_last_q;

    logic [19:0]        prod    [BLK_PIXELS];
    logic [20:0]        sum_l1  [8];
    logic [21:0]        sum_l2  [4];
    logic [22:0]        sum_l3  [2];
    score_t             sum_all;

    // ------------------------------------------------------------------
    // Residual and butterflies
    // ------------------------------------------------------------------

    for (genvar i = 0; i < BLK_PIXELS; i++) begin : g_resid
        assign org_px[i]  = org_i[i*PW +: PW];
        assign pred_px[i] = pred_i[i*PW +: PW];
        assign w_px[i]    = weights_i[i*WW +: WW];
        assign resid[i]   = resid_t'({1'b0, org_px[i]}) - resid_t'({1'b0, pred_px[i]});
    end

    // Horizontal pass, one row at a time
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [9:0] a0, a1, a2, a3;
        assign a0 = resid[4*r+0] + resid[4*r+2];
        assign a1 = resid[4*r+1] + resid[4*r+3];
        assign a2 = resid[4*r+1] - resid[4*r+3];
        assign a3 = resid[4*r+0] - resid[4*r+2];
        assign row_c[4*r+0] = a0 + a1;
        assign row_c[4*r+1] = a3 + a2;
        assign row_c[4*r+2] = a3 - a2;
        assign row_c[4*r+3] = a0 - a1;
    end

    // Vertical pass over the row results
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [11:0] b0, b1, b2, b3;
        assign b0 = row_c[c]   + row_c[8+c];
        assign b1 = row_c[4+c] + row_c[12+c];
        assign b2 = row_c[4+c] - row_c[12+c];
        assign b3 = row_c[c]   - row_c[8+c];
        assign coef[c]    = b0 + b1;
        assign coef[4+c]  = b3 + b2;
        assign coef[8+c]  = b3 - b2;
        assign coef[12+c] = b0 - b1;
    end

    // Stage 1: coefficient magnitudes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= cand_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cand_valid_i) begin
            s1_last_q <= group_last_i;
            for (int k = 0; k < BLK_PIXELS; k++) begin
                abs_q[k] <= abs_coef_t'(coef[k][12] ? -coef[k] : coef[k]);
            end
        end
    end

    // ------------------------------------------------------------------
    // Weighted sum
    // ------------------------------------------------------------------

    for (genvar i = 0; i < BLK_PIXELS; i++) begin : g_prod
        assign prod[i] = abs_q[i] * w_px[i];
    end

    for (genvar i = 0; i < 8; i++) begin : g_l1
        assign sum_l1[i] = prod[2*i] + prod[2*i+1];
    end

    for (genvar i = 0; i < 4; i++) begin : g_l2
        assign sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end

    for (genvar i = 0; i < 2; i++) begin : g_l3
        assign sum_l3[i] = sum_l2[2*i] + sum_l2[2*i+1];
    end

    assign sum_all = sum_l3[0] + sum_l3[1];

    // Stage 2: scaled score
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            satd_valid_o <= 1'b0;
        end else begin
            satd_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            satd_o       <= sum_all >> WEIGHT_SHIFT;
            group_last_o <= s1_last_q;
        end
    end

endmodule : hadamard_cost

`default_nettype wire

/* src/sad_cost.sv */
// 4x4 SAD scorer
`default_nettype none
`timescale 1ns/100ps

module sad_cost (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cand_valid_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0] org_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0] pred_i,
    output cost_pkg::score_t sad_o,
    output logic             sad_valid_o
);

    import pixel_pkg::*;
    import cost_pkg::*;

    localparam int PW = $bits(pixel_t);

    pixel_t org_px  [BLK_PIXELS];
    pixel_t pred_px [BLK_PIXELS];
    pixel_t diff_q  [BLK_PIXELS];
    logic   s1_valid_q;
    score_t diff_sum;

    for (genvar i = 0; i < BLK_PIXELS; i++) begin : g_unpack
        assign org_px[i]  = org_i[i*PW +: PW];
        assign pred_px[i] = pred_i[i*PW +: PW];
    end

    // Stage 1: absolute differences
    always_ff @(posedge clk) begin
        if (cand_valid_i) begin
            for (int k = 0; k < BLK_PIXELS; k++) begin
                diff_q[k] <= (org_px[k] > pred_px[k]) ? org_px[k] - pred_px[k]
                                                      : pred_px[k] - org_px[k];
            end
        end
    end

    always_comb begin
        diff_sum = '0;
        for (int k = 0; k < BLK_PIXELS; k++) begin
            diff_sum = diff_sum + score_t'(diff_q[k]);
        end
    end

    // Stage 2 lines up with the SATD output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q  <= 1'b0;
            sad_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= cand_valid_i;
            sad_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            sad_o <= diff_sum;
        end
    end

endmodule : sad_cost

`default_nettype wire

/* src/cost_select.sv */
// Cost combine, best tracking and result queue
`default_nettype none
`timescale 1ns/100ps

module cost_select #(
    parameter int QUEUE_DEPTH = cost_pkg::DEF_QUEUE_DEPTH,
    parameter int OUT_CREDITS = cost_pkg::DEF_OUT_CREDITS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cost_pkg::score_t    satd_i,
    input  cost_pkg::score_t    sad_i,
    input  logic                score_valid_i,
    input  logic                group_last_i,
    input  cost_pkg::lambda_t   lambda_i,
    input  logic                res_credit_i,
    output cost_pkg::cost_t     cost_o,
    output cost_pkg::cost_t     best_cost_o,
    output cost_pkg::cand_idx_t best_idx_o,
    output logic                group_end_o,
    output logic                res_valid_o,
    output logic                in_credit_o
);

    import cost_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [31:0]      lam_prod;
    cost_t            cost;
    logic             take_best;
    cost_t            next_best;
    cand_idx_t        next_idx;

    cand_idx_t        idx_q;
    cost_t            best_cost_q;
    cand_idx_t        best_idx_q;

    cost_t            q_cost [QUEUE_DEPTH];
    cost_t            q_best [QUEUE_DEPTH];
    cand_idx_t        q_idx  [QUEUE_DEPTH];
    logic             q_last [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] out_crd_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ------------------------------------------------------------------
    // Cost and running best
    // ------------------------------------------------------------------

    // Lambda has 4 fraction bits
    assign lam_prod = lambda_i * sad_i;
    assign cost     = satd_i + cost_t'(lam_prod >> 4);

    // Strict compare keeps the earlier index on a tie
    assign take_best = (idx_q == '0) || (cost < best_cost_q);
    assign next_best = take_best ? cost  : best_cost_q;
    assign next_idx  = take_best ? idx_q : best_idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q       <= '0;
            best_cost_q <= '0;
            best_idx_q  <= '0;
        end else if (score_valid_i) begin
            idx_q       <= group_last_i ? '0 : idx_q + 1'b1;
            best_cost_q <= next_best;
            best_idx_q  <= next_idx;
        end
    end

    // ------------------------------------------------------------------
    // Result queue and credits
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (score_valid_i) begin
            q_cost[wr_ptr_q] <= cost;
            q_best[wr_ptr_q] <= next_best;
            q_idx[wr_ptr_q]  <= next_idx;
            q_last[wr_ptr_q] <= group_last_i;
        end
    end

    // Head leaves once the sink has room
    assign pop = (count_q != '0) && (out_crd_q != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            out_crd_q   <= CRD_W'(OUT_CREDITS);
            res_valid_o <= 1'b0;
            in_credit_o <= 1'b0;
        end else begin
            if (score_valid_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q     <= count_q + CNT_W'(score_valid_i) - CNT_W'(pop);
            out_crd_q   <= out_crd_q + CRD_W'(res_credit_i) - CRD_W'(pop);
            res_valid_o <= pop;
            // Freed entry goes back to the source
            in_credit_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cost_o      <= q_cost[rd_ptr_q];
            best_cost_o <= q_best[rd_ptr_q];
            best_idx_o  <= q_idx[rd_ptr_q];
            group_end_o <= q_last[rd_ptr_q];
        end
    end

endmodule : cost_select

`default_nettype wire

/* src/block_cost_top.sv */
// Block matching cost unit
`default_nettype none
`timescale 1ns/100ps

module block_cost_top #(
    parameter int QUEUE_DEPTH  = cost_pkg::DEF_QUEUE_DEPTH,
    parameter int WEIGHT_SHIFT = cost_pkg::DEF_WEIGHT_SHIFT,
    parameter int OUT_CREDITS  = cost_pkg::DEF_OUT_CREDITS
) (
    input  logic                clk,
    input  logic                rst_n,

    // Candidate side
    input  logic                cand_valid_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0]  org_i,
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::pixel_t)-1:0]  pred_i,
    input  logic                group_last_i,
    output logic                in_credit_o,

    // Configuration
    input  logic [pixel_pkg::BLK_PIXELS*$bits(pixel_pkg::weight_t)-1:0] weights_i,
    input  cost_pkg::lambda_t   lambda_i,

    // Result side
    input  logic                res_credit_i,
    output logic                res_valid_o,
    output cost_pkg::cost_t     cost_o,
    output cost_pkg::cost_t     best_cost_o,
    output cost_pkg::cand_idx_t best_idx_o,
    output logic                group_end_o
);

    import cost_pkg::*;

    score_t satd;
    logic   satd_valid;
    logic   satd_last;
    score_t sad;

    hadamard_cost #(
        .WEIGHT_SHIFT (WEIGHT_SHIFT)
    ) u_hadamard_cost (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid_i (cand_valid_i),
        .org_i        (org_i),
        .pred_i       (pred_i),
        .weights_i    (weights_i),
        .group_last_i (group_last_i),
        .satd_o       (satd),
        .satd_valid_o (satd_valid),
        .group_last_o (satd_last)
    );

    // Same latency as the SATD path, its valid is redundant
    sad_cost u_sad_cost (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid_i (cand_valid_i),
        .org_i        (org_i),
        .pred_i       (pred_i),
        .sad_o        (sad),
        .sad_valid_o  ()
    );

    cost_select #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .OUT_CREDITS   (OUT_CREDITS)
    ) u_cost_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .satd_i        (satd),
        .sad_i         (sad),
        .score_valid_i (satd_valid),
        .group_last_i  (satd_last),
        .lambda_i      (lambda_i),
        .res_credit_i  (res_credit_i),
        .cost_o        (cost_o),
        .best_cost_o   (best_cost_o),
        .best_idx_o    (best_idx_o),
        .group_end_o   (group_end_o),
        .res_valid_o   (res_valid_o),
        .in_credit_o   (in_credit_o)
    );

endmodule : block_cost_top

`default_nettype wire

/* tb/cost_checker.sv */
// Block cost result checker
`default_nettype none
`timescale 1ns/100ps

module cost_checker #(
    parameter int QUEUE_DEPTH  = cost_pkg::DEF_QUEUE_DEPTH,
    parameter int WEIGHT_SHIFT = cost_pkg::DEF_WEIGHT_SHIFT,
    parameter int OUT_CREDITS  = cost_pkg::DEF_OUT_CREDITS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cand_valid_i,
    input  logic [pixel_pkg::BLK_PIXELS*8-1:0] org_i,
    input  logic [pixel_pkg::BLK_PIXELS*8-1:0] pred_i,
    input  logic                group_last_i,
    input  logic [pixel_pkg::BLK_PIXELS*8-1:0] weights_i,
    input  cost_pkg::lambda_t   lambda_i,
    input  logic                in_credit_i,
    input  logic                res_valid_i,
    input  logic                res_credit_i,
    input  cost_pkg::cost_t     cost_i,
    input  cost_pkg::cost_t     best_cost_i,
    input  cost_pkg::cand_idx_t best_idx_i,
    input  logic                group_end_i,
    output int                  err_cnt_o,
    output int                  cand_cnt_o,
    output int                  res_cnt_o
);

    import pixel_pkg::*;
    import cost_pkg::*;

    localparam int BW = BLK_PIXELS * 8;

    // Minus signs of the sequency ordered Hadamard matrix at bit 4*row+col
    localparam logic [15:0] H_NEG = 16'ha6c0;

    cost_t     exp_cost [$];
    cost_t     exp_best [$];
    cand_idx_t exp_idx  [$];
    logic      exp_last [$];

    int        n_err = 0;
    int        n_cand = 0;
    int        n_res = 0;
    int        grp_idx;
    longint    grp_best;
    int        grp_best_idx;
    int        out_crd;
    // Input credits the DUT still owes the source
    int        outstanding;

    assign err_cnt_o  = n_err;
    assign cand_cnt_o = n_cand;
    assign res_cnt_o  = n_res;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic int hsign(input int row, input int col);
        return H_NEG[4*row+col] ? -1 : 1;
    endfunction

    function automatic int residual(input logic [BW-1:0] org, input logic [BW-1:0] pred,
                                    input int k);
        return int'(org[8*k +: 8]) - int'(pred[8*k +: 8]);
    endfunction

    // Coefficient (i,j) of H * R * H transposed times weight 4*i+j
    function automatic longint model_satd(input logic [BW-1:0] org, input logic [BW-1:0] pred,
                                          input logic [BW-1:0] w);
        longint sum;
        int     acc;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                acc = 0;
                for (int u = 0; u < 4; u++) begin
                    for (int v = 0; v < 4; v++) begin
                        acc += hsign(i, u) * hsign(j, v) * residual(org, pred, 4*u+v);
                    end
                end
                if (acc < 0) begin
                    acc = -acc;
                end
                sum += longint'(acc) * longint'(w[8*(4*i+j) +: 8]);
            end
        end
        return sum >> WEIGHT_SHIFT;
    endfunction

    function automatic longint model_sad(input logic [BW-1:0] org, input logic [BW-1:0] pred);
        longint sum;
        int     d;
        sum = 0;
        for (int k = 0; k < BLK_PIXELS; k++) begin
            d = residual(org, pred, k);
            sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        n_err++;
    endtask

    task automatic check_field(input string name, input longint exp, input longint act);
        if (exp != act) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            n_err++;
        end
    endtask

    // ------------------------------------------------------------------
    // Port watcher
    // ------------------------------------------------------------------

    always @(posedge clk) begin : watch
        longint c;
        if (!rst_n) begin
            grp_idx      = 0;
            grp_best     = 0;
            grp_best_idx = 0;
            out_crd      = OUT_CREDITS;
            outstanding  = 0;
        end else begin
            if (in_credit_i) begin
                if (outstanding == 0) begin
                    report_error("Input credit returned with no candidate outstanding");
                end else begin
                    outstanding--;
                end
            end
            if (cand_valid_i) begin
                c = model_satd(org_i, pred_i, weights_i)
                    + ((longint'(lambda_i) * model_sad(org_i, pred_i)) >> 4);
                // Strictly lower cost wins, so ties keep the earlier index
                if (grp_idx == 0 || c < grp_best) begin
                    grp_best     = c;
                    grp_best_idx = grp_idx;
                end
                exp_cost.push_back(cost_t'(c));
                exp_best.push_back(cost_t'(grp_best));
                exp_idx.push_back(cand_idx_t'(grp_best_idx));
                exp_last.push_back(group_last_i);
                grp_idx = group_last_i ? 0 : grp_idx + 1;
                outstanding++;
                n_cand++;
                // Candidates still waiting for their result
                if (exp_cost.size() > QUEUE_DEPTH) begin
                    report_error($sformatf("%0d candidates await results, limit is %0d",
                                           exp_cost.size(), QUEUE_DEPTH));
                end
            end
            if (res_valid_i) begin
                if (out_crd == 0) begin
                    report_error("A result was sent without a credit");
                end else begin
                    out_crd--;
                end
                if (exp_cost.size() == 0) begin
                    report_error("A result arrived with no candidate pending");
                end else begin
                    check_field("cost_o", exp_cost.pop_front(), cost_i);
                    check_field("best_cost_o", exp_best.pop_front(), best_cost_i);
                    check_field("best_idx_o", exp_idx.pop_front(), best_idx_i);
                    check_field("group_end_o", exp_last.pop_front(), group_end_i);
                end
                n_res++;
            end
            if (res_credit_i) begin
                out_crd++;
            end
        end
    end

endmodule : cost_checker

`default_nettype wire

/* tb/tb_top.sv */
// Block cost unit testbench
`default_nettype none
`timescale 1ns/100ps

module tb_top;

    import pixel_pkg::*;
    import cost_pkg::*;

    localparam int QUEUE_DEPTH  = DEF_QUEUE_DEPTH;
    localparam int WEIGHT_SHIFT = DEF_WEIGHT_SHIFT;
    localparam int OUT_CREDITS  = DEF_OUT_CREDITS;
    localparam int BW           = BLK_PIXELS * 8;
    // Largest candidate count over all tests
    localparam int MAX_CANDS    = 4 + 24 + 80 + 16 + 16;
    localparam int CYCLE_LIMIT  = 40 * MAX_CANDS + 100;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          cand_valid_i = 1'b0;
    logic [BW-1:0] org_i = '0;
    logic [BW-1:0] pred_i = '0;
    logic          group_last_i = 1'b0;
    logic [BW-1:0] weights_i;
    lambda_t       lambda_i;
    logic          res_credit_i = 1'b0;
    logic          in_credit_o;
    logic          res_valid_o;
    cost_t         cost_o;
    cost_t         best_cost_o;
    cand_idx_t     best_idx_o;
    logic          group_end_o;

    logic [31:0]   rng_state = 32'h5abe_abc9;
    logic [BW-1:0] stim_org  [$];
    logic [BW-1:0] stim_pred [$];
    logic          stim_last [$];
    int            in_credits = QUEUE_DEPTH;
    int            sink_due [$];
    logic          sink_hold = 1'b0;
    int            cycle_cnt = 0;
    int            err_cnt;
    int            cand_cnt;
    int            res_cnt;
    int            tb_errs = 0;
    int            tests_failed = 0;

    always #5 clk = ~clk;

    block_cost_top #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .WEIGHT_SHIFT (WEIGHT_SHIFT),
        .OUT_CREDITS  (OUT_CREDITS)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid_i (cand_valid_i),
        .org_i        (org_i),
        .pred_i       (pred_i),
        .group_last_i (group_last_i),
        .in_credit_o  (in_credit_o),
        .weights_i    (weights_i),
        .lambda_i     (lambda_i),
        .res_credit_i (res_credit_i),
        .res_valid_o  (res_valid_o),
        .cost_o       (cost_o),
        .best_cost_o  (best_cost_o),
        .best_idx_o   (best_idx_o),
        .group_end_o  (group_end_o)
    );

    cost_checker #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .WEIGHT_SHIFT (WEIGHT_SHIFT),
        .OUT_CREDITS  (OUT_CREDITS)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid_i (cand_valid_i),
        .org_i        (org_i),
        .pred_i       (pred_i),
        .group_last_i (group_last_i),
        .weights_i    (weights_i),
        .lambda_i     (lambda_i),
        .in_credit_i  (in_credit_o),
        .res_valid_i  (res_valid_o),
        .res_credit_i (res_credit_i),
        .cost_i       (cost_o),
        .best_cost_i  (best_cost_o),
        .best_idx_i   (best_idx_o),
        .group_end_i  (group_end_o),
        .err_cnt_o    (err_cnt),
        .cand_cnt_o   (cand_cnt),
        .res_cnt_o    (res_cnt)
    );

    // ------------------------------------------------------------------
    // Random numbers and stimulus helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_range(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    function automatic logic [BW-1:0] rand_block();
        logic [BW-1:0] blk;
        logic [31:0]   r;
        for (int k = 0; k < BLK_PIXELS; k++) begin
            r = lcg_next();
            blk[k*8 +: 8] = r[23:16];
        end
        return blk;
    endfunction

    task automatic push_cand(input logic [BW-1:0] org, input logic [BW-1:0] pred,
                             input logic last);
        stim_org.push_back(org);
        stim_pred.push_back(pred);
        stim_last.push_back(last);
    endtask

    // Only called while nothing is in flight
    task automatic set_config(input logic [BW-1:0] w, input lambda_t lam);
        @(posedge clk);
        weights_i <= w;
        lambda_i  <= lam;
        @(negedge clk);
    endtask

    function automatic bit is_drained();
        return stim_org.size() == 0 && !cand_valid_i && cand_cnt == res_cnt
               && in_credits == QUEUE_DEPTH && sink_due.size() == 0;
    endfunction

    task automatic wait_drain(input string name, input int max_cycles);
        int n;
        n = 0;
        while (!is_drained() && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!is_drained()) begin
            $display("Results of %s did not drain within %0d cycles", name, max_cycles);
            tb_errs++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = err_cnt + tb_errs - errs_before;
        if (errs == 0) begin
            $display("Test %-24s ok", name);
        end else begin
            $display("Test %-24s failed with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------------
    // Source, sink and timeout
    // ------------------------------------------------------------------

    // Sends at full rate while credits last
    always @(posedge clk) begin : source
        if (!rst_n) begin
            in_credits = QUEUE_DEPTH;
            cand_valid_i <= 1'b0;
        end else begin
            if (in_credit_o) begin
                in_credits = in_credits + 1;
            end
            if (stim_org.size() > 0 && in_credits > 0) begin
                cand_valid_i <= 1'b1;
                org_i        <= stim_org.pop_front();
                pred_i       <= stim_pred.pop_front();
                group_last_i <= stim_last.pop_front();
                in_credits = in_credits - 1;
            end else begin
                cand_valid_i <= 1'b0;
            end
        end
    end

    // Each result returns its credit 0 to 3 cycles later
    always @(posedge clk) begin : sink
        logic [31:0] r;
        res_credit_i <= 1'b0;
        if (rst_n) begin
            if (res_valid_o) begin
                r = lcg_next();
                sink_due.push_back(cycle_cnt + int'(r[17:16]));
            end
            if (!sink_hold && sink_due.size() > 0 && sink_due[0] <= cycle_cnt) begin
                void'(sink_due.pop_front());
                res_credit_i <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin : main
        logic [BW-1:0] org;
        logic [BW-1:0] pred;
        int            len;
        int            base;
        rst_n     = 1'b0;
        weights_i = '0;
        lambda_i  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Identical blocks
        base = err_cnt + tb_errs;
        set_config(rand_block(), lambda_t'(rand_range(256)));
        for (int k = 0; k < 4; k++) begin
            org = rand_block();
            push_cand(org, org, k == 3);
        end
        wait_drain("zero residual", 1000);
        end_test("zero residual", base);

        // Unit weights give the plain SATD
        base = err_cnt + tb_errs;
        set_config({BLK_PIXELS{8'd16}}, 8'd0);
        for (int k = 0; k < 24; k++) begin
            push_cand(rand_block(), rand_block(), k % 4 == 3);
        end
        wait_drain("unit weights", 2000);
        end_test("unit weights", base);

        // Repeated blocks inside a group force ties
        base = err_cnt + tb_errs;
        set_config(rand_block(), lambda_t'(rand_range(256)));
        for (int g = 0; g < 10; g++) begin
            len = 1 + rand_range(8);
            for (int j = 0; j < len; j++) begin
                if (j == 0 || rand_range(4) != 0) begin
                    org  = rand_block();
                    pred = rand_block();
                end
                push_cand(org, pred, j == len - 1);
            end
        end
        wait_drain("random weights", 4000);
        end_test("random weights", base);

        base = err_cnt + tb_errs;
        set_config('0, 8'd16);
        for (int k = 0; k < 16; k++) begin
            push_cand(rand_block(), rand_block(), k % 8 == 7);
        end
        wait_drain("sad only", 2000);
        end_test("sad only", base);

        // Sink stalls while the source keeps sending
        base = err_cnt + tb_errs;
        set_config(rand_block(), lambda_t'(rand_range(256)));
        sink_hold = 1'b1;
        for (int k = 0; k < 16; k++) begin
            push_cand(rand_block(), rand_block(), k % 4 == 3);
        end
        repeat (30) @(negedge clk);
        if (in_credits != 0) begin
            $display("Source was not stalled, it still holds %0d credits", in_credits);
            tb_errs++;
        end
        sink_hold = 1'b0;
        wait_drain("back-pressure", 2000);
        end_test("back-pressure", base);

        base = err_cnt + tb_errs;
        repeat (10) @(negedge clk);
        if (cand_cnt != res_cnt) begin
            $display("Missing results, %0d candidates accepted but %0d results seen",
                     cand_cnt, res_cnt);
            tb_errs++;
        end
        if (in_credits != QUEUE_DEPTH) begin
            $display("Missing credits, source holds %0d of %0d", in_credits, QUEUE_DEPTH);
            tb_errs++;
        end
        end_test("drain", base);

        $display("Tests failed: %0d of 6, results checked: %0d, errors: %0d",
                 tests_failed, res_cnt, err_cnt + tb_errs);
        if (tests_failed == 0 && err_cnt + tb_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_top

`default_nettype wire

/* flist.f */
common/pixel_pkg.sv
common/cost_pkg.sv
hadamard/hadamard_cost.sv
src/sad_cost.sv
src/cost_select.sv
src/block_cost_top.sv
tb/cost_checker.sv
tb/tb_top.sv

/* Makefile */
# Verilator build for the block cost unit

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal --timescale 1ns/100ps
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
